// File: include/htu_params.svh
`ifndef HTU_PARAMS_SVH
`define HTU_PARAMS_SVH

// bank geometry
`define HTU_SETS      8
`define HTU_WAYS      8

// 32-byte line split into two 16-byte offsets
`define HTU_TAG_W     22
`define HTU_ADDR_LSB  4

// crossbar side fields
`define HTU_CH_W      2
`define HTU_WBUF_W    8

`endif

// File: src/htu_op_pkg.sv
`default_nettype none

package htu_op_pkg;

  // crossbar opcode
  typedef enum logic [1:0] {
    op_read       = 2'b00,
    op_write      = 2'b01,
    op_flush      = 2'b10,
    op_invalidate = 2'b11
  } mcash_op_e;

  // state of one 16-byte offset
  // 2'b10 is not a legal encoding
  typedef enum logic [1:0] {
    ls_empty = 2'b00,
    ls_clean = 2'b01,
    ls_dirty = 2'b11
  } line_state_e;

endpackage

`default_nettype wire

// File: src/htu_addr_pkg.sv
`default_nettype none

`include "htu_params.svh"

package htu_addr_pkg;

  localparam int SET_W = $clog2(`HTU_SETS);
  localparam int WAY_W = $clog2(`HTU_WAYS);

  // address bits 31..10
  typedef logic [`HTU_TAG_W-1:0] tag_t;

  // address bits 7..5
  typedef logic [SET_W-1:0] set_idx_t;

  typedef logic [WAY_W-1:0] way_t;

  // set in the upper bits, way below
  typedef struct packed {
    set_idx_t set_idx;
    way_t     way;
  } set_way_t;

endpackage

`default_nettype wire

// File: src/htu_lookup_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "htu_params.svh"

interface htu_lookup_if;

  // request side, one copy shared by all sets
  logic                    acc_fire;
  logic [`HTU_SETS-1:0]    set_sel;
  htu_addr_pkg::tag_t      acc_tag;
  logic                    acc_offset;
  htu_op_pkg::mcash_op_e   acc_op;

  // linefill done from the issue unit
  logic                    done_valid;
  htu_addr_pkg::set_way_t  done_set_way;

  // per-set results, one element per entry
  logic                    hit        [`HTU_SETS];
  htu_addr_pkg::way_t      way        [`HTU_SETS];
  logic                    evict      [`HTU_SETS];
  htu_op_pkg::line_state_e off0_state [`HTU_SETS];
  htu_op_pkg::line_state_e off1_state [`HTU_SETS];

  modport lookup (
    output acc_fire, set_sel, acc_tag, acc_offset, acc_op,
    output done_valid, done_set_way,
    input  hit, way, evict, off0_state, off1_state
  );

  modport entry (
    input  acc_fire, set_sel, acc_tag, acc_offset, acc_op,
    input  done_valid, done_set_way,
    output hit, way, evict, off0_state, off1_state
  );

endinterface

`default_nettype wire

// File: src/bank_htu_lookup.sv
`timescale 1ns/10ps
`default_nettype none

`include "htu_params.svh"

module bank_htu_lookup (
  htu_lookup_if.lookup                              lu,
  input  wire                                       req_valid_i,
  input  wire  [`HTU_CH_W-1:0]                      req_ch_id_i,
  input  wire  [1:0]                                req_opcode_i,
  input  wire  [31:`HTU_ADDR_LSB]                   req_addr_i,
  input  wire  [`HTU_WBUF_W-1:0]                    req_wbuf_id_i,
  input  wire                                       isu_allow_in_i,
  input  wire                                       done_valid_i,
  input  wire  [htu_addr_pkg::SET_W+htu_addr_pkg::WAY_W-1:0] done_set_way_i,
  output logic                                      req_ready_o,
  output logic                                      isu_valid_o,
  output logic [`HTU_CH_W-1:0]                      isu_ch_id_o,
  output logic [1:0]                                isu_opcode_o,
  output logic [htu_addr_pkg::SET_W+htu_addr_pkg::WAY_W:0] isu_set_way_offset_o,
  output logic [`HTU_WBUF_W-1:0]                    isu_wbuf_id_o,
  output logic [1:0]                                isu_off0_state_o,
  output logic [1:0]                                isu_off1_state_o,
  output logic                                      linefill_valid_o,
  output logic [htu_addr_pkg::SET_W-1:0]            linefill_set_o,
  output logic [htu_addr_pkg::WAY_W-1:0]            linefill_way_o
);

  htu_op_pkg::mcash_op_e   req_op;
  htu_addr_pkg::set_idx_t  req_set;
  logic                    req_offset;
  logic                    op_is_read;
  logic                    op_is_write;
  logic                    sel_hit;
  logic                    sel_evict;
  htu_addr_pkg::way_t      sel_way;
  htu_op_pkg::line_state_e sel_off0;
  htu_op_pkg::line_state_e sel_off1;
  htu_op_pkg::line_state_e acc_state;

  // ------------------------------------------------------------------
  // request decode
  // ------------------------------------------------------------------
  assign req_op      = htu_op_pkg::mcash_op_e'(req_opcode_i);
  assign op_is_read  = req_op == htu_op_pkg::op_read;
  assign op_is_write = req_op == htu_op_pkg::op_write;

  assign req_offset = req_addr_i[`HTU_ADDR_LSB];
  assign req_set    = req_addr_i[`HTU_ADDR_LSB+1 +: htu_addr_pkg::SET_W];

  assign lu.acc_fire     = req_valid_i & isu_allow_in_i;
  assign lu.set_sel      = {{(`HTU_SETS-1){1'b0}}, 1'b1} << req_set;
  assign lu.acc_tag      = req_addr_i[31 -: `HTU_TAG_W];
  assign lu.acc_offset   = req_offset;
  assign lu.acc_op       = req_op;
  assign lu.done_valid   = done_valid_i;
  assign lu.done_set_way = done_set_way_i;

  // ------------------------------------------------------------------
  // addressed set result
  // ------------------------------------------------------------------
  assign sel_hit   = lu.hit[req_set];
  assign sel_way   = lu.way[req_set];
  assign sel_evict = lu.evict[req_set];
  assign sel_off0  = lu.off0_state[req_set];
  assign sel_off1  = lu.off1_state[req_set];
  assign acc_state = req_offset ? sel_off1 : sel_off0;

  // ------------------------------------------------------------------
  // issue unit side
  // ------------------------------------------------------------------
  assign req_ready_o   = isu_allow_in_i;
  assign isu_valid_o   = req_valid_i;
  assign isu_ch_id_o   = req_ch_id_i;
  assign isu_wbuf_id_o = req_wbuf_id_i;

  // bit 1 evict, bit 0 write
  assign isu_opcode_o[0] = op_is_write;
  assign isu_opcode_o[1] = req_valid_i & (op_is_read | op_is_write) & sel_evict;

  assign isu_set_way_offset_o = {req_set, sel_way, req_offset};
  assign isu_off0_state_o     = sel_off0;
  assign isu_off1_state_o     = sel_off1;

  // read miss, or read hit on an offset that was never filled
  assign linefill_valid_o = req_valid_i & op_is_read
                          & (~sel_hit | (acc_state == htu_op_pkg::ls_empty));
  assign linefill_set_o   = req_set;
  assign linefill_way_o   = sel_way;

endmodule

`default_nettype wire

// File: src/bank_htu_set_entry.sv
`timescale 1ns/10ps
`default_nettype none

`include "htu_params.svh"

module bank_htu_set_entry #(
  parameter int SET_ID = 0
) (
  input wire           clk_i,
  input wire           rst_i,
  htu_lookup_if.entry  en
);

  localparam htu_addr_pkg::set_idx_t MY_SET = htu_addr_pkg::set_idx_t'(SET_ID);

  htu_addr_pkg::tag_t      tag_q  [`HTU_WAYS];
  logic [`HTU_WAYS-1:0]    valid_q;
  htu_op_pkg::line_state_e off0_q [`HTU_WAYS];
  htu_op_pkg::line_state_e off1_q [`HTU_WAYS];
  htu_addr_pkg::way_t      victim_q;

  logic [`HTU_WAYS-1:0]    hit_vec;
  logic                    hit;
  htu_addr_pkg::way_t      hit_way;
  htu_addr_pkg::way_t      acc_way;
  logic                    is_rd;
  logic                    is_wr;
  logic                    acc_here;
  logic                    done_here;
  logic                    alloc;
  logic                    victim_dirty;

  // ------------------------------------------------------------------
  // tag compare
  // ------------------------------------------------------------------
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `HTU_WAYS; w++) begin
      hit_vec[w] = valid_q[w] & (tag_q[w] == en.acc_tag);
      if (hit_vec[w]) begin
        hit_way = htu_addr_pkg::way_t'(w);
      end
    end
  end

  assign hit     = |hit_vec;
  assign acc_way = hit ? hit_way : victim_q;

  assign victim_dirty = (off0_q[victim_q] == htu_op_pkg::ls_dirty)
                      | (off1_q[victim_q] == htu_op_pkg::ls_dirty);

  assign en.hit[SET_ID]        = hit;
  assign en.way[SET_ID]        = acc_way;
  assign en.evict[SET_ID]      = ~hit & valid_q[victim_q] & victim_dirty;
  assign en.off0_state[SET_ID] = off0_q[acc_way];
  assign en.off1_state[SET_ID] = off1_q[acc_way];

  // ------------------------------------------------------------------
  // update on accept
  // ------------------------------------------------------------------
  assign is_rd     = en.acc_op == htu_op_pkg::op_read;
  assign is_wr     = en.acc_op == htu_op_pkg::op_write;
  assign acc_here  = en.acc_fire & en.set_sel[SET_ID];
  assign done_here = en.done_valid & (en.done_set_way.set_idx == MY_SET);
  // flush and invalidate fall through untouched
  assign alloc     = acc_here & ~hit & (is_rd | is_wr);

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      tag_q[victim_q] <= en.acc_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q  <= '0;
      victim_q <= '0;
      for (int w = 0; w < `HTU_WAYS; w++) begin
        off0_q[w] <= htu_op_pkg::ls_empty;
        off1_q[w] <= htu_op_pkg::ls_empty;
      end
    end else begin
      // linefill finished, whole line now matches memory
      if (done_here) begin
        off0_q[en.done_set_way.way] <= htu_op_pkg::ls_clean;
        off1_q[en.done_set_way.way] <= htu_op_pkg::ls_clean;
      end
      if (alloc) begin
        valid_q[victim_q] <= 1'b1;
        off0_q[victim_q]  <= htu_op_pkg::ls_empty;
        off1_q[victim_q]  <= htu_op_pkg::ls_empty;
        if (is_wr && en.acc_offset) begin
          off1_q[victim_q] <= htu_op_pkg::ls_dirty;
        end else if (is_wr) begin
          off0_q[victim_q] <= htu_op_pkg::ls_dirty;
        end
        // round robin, wraps at 8
        victim_q <= victim_q + 1'b1;
      end else if (acc_here && hit && is_wr) begin
        if (en.acc_offset) begin
          off1_q[hit_way] <= htu_op_pkg::ls_dirty;
        end else begin
          off0_q[hit_way] <= htu_op_pkg::ls_dirty;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/bank_htu.sv
`timescale 1ns/10ps
`default_nettype none

`include "htu_params.svh"

module bank_htu (
  input  wire                                        clk_i,
  input  wire                                        rst_i,
  // crossbar request
  input  wire                                        xbar_bank_htu_valid_i,
  output logic                                       xbar_bank_htu_ready_o,
  input  wire  [`HTU_CH_W-1:0]                       xbar_bank_htu_ch_id_i,
  input  wire  [1:0]                                 xbar_bank_htu_opcode_i,
  input  wire  [31:`HTU_ADDR_LSB]                    xbar_bank_htu_addr_i,
  input  wire  [`HTU_WBUF_W-1:0]                     xbar_bank_htu_wbuffer_id_i,
  // to issue unit
  output logic                                       htu_isu_valid_o,
  input  wire                                        htu_isu_allow_in_i,
  output logic [`HTU_CH_W-1:0]                       htu_isu_ch_id_o,
  output logic [1:0]                                 htu_isu_opcode_o,
  output logic [htu_addr_pkg::SET_W+htu_addr_pkg::WAY_W:0] htu_isu_set_way_offset_o,
  output logic [`HTU_WBUF_W-1:0]                     htu_isu_wbuffer_id_o,
  output logic [1:0]                                 htu_isu_offset0_state_o,
  output logic [1:0]                                 htu_isu_offset1_state_o,
  output logic                                       htu_isu_linefill_valid_o,
  output logic [htu_addr_pkg::SET_W-1:0]             htu_isu_linefill_set_o,
  output logic [htu_addr_pkg::WAY_W-1:0]             htu_isu_linefill_way_o,
  // from issue unit
  input  wire                                        isu_htu_already_done_valid_i,
  input  wire  [htu_addr_pkg::SET_W+htu_addr_pkg::WAY_W-1:0] isu_htu_set_way_i
);

  htu_lookup_if lu_if ();

  // ------------------------------------------------------------------
  // decode and result select
  // ------------------------------------------------------------------
  bank_htu_lookup u_lookup (
    .lu                   (lu_if.lookup                 ),
    .req_valid_i          (xbar_bank_htu_valid_i        ),
    .req_ch_id_i          (xbar_bank_htu_ch_id_i        ),
    .req_opcode_i         (xbar_bank_htu_opcode_i       ),
    .req_addr_i           (xbar_bank_htu_addr_i         ),
    .req_wbuf_id_i        (xbar_bank_htu_wbuffer_id_i   ),
    .isu_allow_in_i       (htu_isu_allow_in_i           ),
    .done_valid_i         (isu_htu_already_done_valid_i ),
    .done_set_way_i       (isu_htu_set_way_i            ),
    .req_ready_o          (xbar_bank_htu_ready_o        ),
    .isu_valid_o          (htu_isu_valid_o              ),
    .isu_ch_id_o          (htu_isu_ch_id_o              ),
    .isu_opcode_o         (htu_isu_opcode_o             ),
    .isu_set_way_offset_o (htu_isu_set_way_offset_o     ),
    .isu_wbuf_id_o        (htu_isu_wbuffer_id_o         ),
    .isu_off0_state_o     (htu_isu_offset0_state_o      ),
    .isu_off1_state_o     (htu_isu_offset1_state_o      ),
    .linefill_valid_o     (htu_isu_linefill_valid_o     ),
    .linefill_set_o       (htu_isu_linefill_set_o       ),
    .linefill_way_o       (htu_isu_linefill_way_o       )
  );

  // ------------------------------------------------------------------
  // set array
  // ------------------------------------------------------------------
  genvar s;
  generate
    for (s = 0; s < `HTU_SETS; s++) begin : g_set
      bank_htu_set_entry #(
        .SET_ID (s)
      ) u_set_entry (
        .clk_i (clk_i        ),
        .rst_i (rst_i        ),
        .en    (lu_if.entry  )
      );
    end
  endgenerate

endmodule

`default_nettype wire

// File: test/bank_htu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module bank_htu_assertions (
  input wire       clk_i,
  input wire       rst_i,
  input wire       valid_i,
  input wire       ready_i,
  input wire       allow_in_i,
  input wire [1:0] opcode_i,
  input wire       isu_valid_i,
  input wire       linefill_i
);

  // ready is a straight copy of allowIn
  ap_ready: assert property (@(posedge clk_i) disable iff (rst_i) ready_i == allow_in_i)
    else $error("ready differs from allowIn");

  // linefill only ever comes from a read
  ap_no_fill_on_write: assert property (@(posedge clk_i) disable iff (rst_i)
    !(linefill_i && opcode_i == htu_op_pkg::op_write))
    else $error("linefill raised on a write");

  ap_isu_valid: assert property (@(posedge clk_i) disable iff (rst_i) isu_valid_i == valid_i)
    else $error("issue unit valid differs from crossbar valid");

endmodule

bind bank_htu bank_htu_assertions u_assertions (
  .clk_i       (clk_i                   ),
  .rst_i       (rst_i                   ),
  .valid_i     (xbar_bank_htu_valid_i   ),
  .ready_i     (xbar_bank_htu_ready_o   ),
  .allow_in_i  (htu_isu_allow_in_i      ),
  .opcode_i    (xbar_bank_htu_opcode_i  ),
  .isu_valid_i (htu_isu_valid_o         ),
  .linefill_i  (htu_isu_linefill_valid_o)
);

`default_nettype wire

// File: test/tb_bank_htu.sv
`timescale 1ns/10ps
`default_nettype none

`include "htu_params.svh"

module tb_bank_htu;

  localparam logic [1:0] RD = htu_op_pkg::op_read;
  localparam logic [1:0] WR = htu_op_pkg::op_write;
  localparam logic [1:0] E = htu_op_pkg::ls_empty;
  localparam logic [1:0] C = htu_op_pkg::ls_clean;
  localparam logic [1:0] D = htu_op_pkg::ls_dirty;
  localparam int READY_TIMEOUT = 20;

  // stimulus first, then expected ready, linefill, evict, way and states
  typedef struct packed {
    logic [3:0]  test;
    logic        valid;
    logic        allow;
    logic [1:0]  op;
    logic [31:4] addr;
    logic        done;
    logic [5:0]  done_sw;
    logic        rdy;
    logic        fill;
    logic        evict;
    logic [2:0]  way;
    logic [1:0]  off0;
    logic [1:0]  off1;
  } row_t;

  logic clk_i, rst_i, xbar_bank_htu_valid_i, xbar_bank_htu_ready_o;
  logic htu_isu_valid_o, htu_isu_allow_in_i, htu_isu_linefill_valid_o;
  logic isu_htu_already_done_valid_i;
  logic [`HTU_CH_W-1:0] xbar_bank_htu_ch_id_i, htu_isu_ch_id_o;
  logic [`HTU_WBUF_W-1:0] xbar_bank_htu_wbuffer_id_i, htu_isu_wbuffer_id_o;
  logic [1:0] xbar_bank_htu_opcode_i, htu_isu_opcode_o;
  logic [1:0] htu_isu_offset0_state_o, htu_isu_offset1_state_o;
  logic [31:`HTU_ADDR_LSB] xbar_bank_htu_addr_i;
  logic [6:0] htu_isu_set_way_offset_o;
  logic [2:0] htu_isu_linefill_set_o, htu_isu_linefill_way_o;
  logic [5:0] isu_htu_set_way_i;

  row_t rows[$];
  htu_addr_pkg::tag_t tags [10];
  string test_name [5] = '{"cold read miss", "linefill done", "write hit",
                           "round robin wrap", "back pressure"};
  integer seed;
  int checks;
  int errors;

  bank_htu DUT (.*);

  always #4 clk_i = ~clk_i;

  // every request goes to set 3
  function automatic logic [31:4] addr_of(input htu_addr_pkg::tag_t tag, input logic off);
    return {tag, 2'b00, 3'd3, off};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  initial begin
    row_t r;
    int first_err;
    int n_tests;
    int cycles;
    bit fresh;
    bit timed_out;
    clk_i = 1'b0;
    rst_i = 1'b1;
    xbar_bank_htu_valid_i = 1'b0;
    xbar_bank_htu_ch_id_i = '0;
    xbar_bank_htu_opcode_i = RD;
    xbar_bank_htu_addr_i = '0;
    xbar_bank_htu_wbuffer_id_i = '0;
    htu_isu_allow_in_i = 1'b1;
    isu_htu_already_done_valid_i = 1'b0;
    isu_htu_set_way_i = '0;
    timed_out = 1'b0;
    first_err = 0;
    n_tests = 0;

    // ten distinct tags
    seed = 32'h2ad;
    for (int i = 0; i < 10; i++) begin
      do begin
        tags[i] = htu_addr_pkg::tag_t'($random(seed));
        fresh = 1'b1;
        for (int j = 0; j < i; j++) begin
          if (tags[j] == tags[i]) fresh = 1'b0;
        end
      end while (!fresh);
    end

    rows.push_back(row_t'{1, 1, 1, RD, addr_of(tags[0], 0), 0, 0, 1, 1, 0, 0, E, E});
    rows.push_back(row_t'{1, 1, 1, RD, addr_of(tags[0], 0), 0, 0, 1, 1, 0, 0, E, E});
    rows.push_back(row_t'{2, 0, 1, RD, addr_of(tags[0], 0), 1, 6'o30, 1, 0, 0, 0, E, E});
    rows.push_back(row_t'{2, 1, 1, RD, addr_of(tags[0], 0), 0, 0, 1, 0, 0, 0, C, C});
    rows.push_back(row_t'{3, 1, 1, WR, addr_of(tags[0], 1), 0, 0, 1, 0, 0, 0, C, C});
    rows.push_back(row_t'{3, 1, 1, RD, addr_of(tags[0], 0), 0, 0, 1, 0, 0, 0, C, D});
    for (int k = 1; k < 8; k++) begin
      rows.push_back(row_t'{4, 1, 1, RD, addr_of(tags[k], 0), 0, 0, 1, 1, 0, k, E, E});
    end
    // way 0 holds a dirty offset when the pointer wraps
    rows.push_back(row_t'{4, 1, 1, RD, addr_of(tags[8], 0), 0, 0, 1, 1, 1, 0, C, D});
    // held write miss leaves way 1 untouched
    rows.push_back(row_t'{5, 1, 0, WR, addr_of(tags[9], 0), 0, 0, 0, 0, 0, 1, E, E});
    rows.push_back(row_t'{5, 1, 0, WR, addr_of(tags[9], 0), 0, 0, 0, 0, 0, 1, E, E});
    rows.push_back(row_t'{5, 1, 1, WR, addr_of(tags[9], 0), 0, 0, 1, 0, 0, 1, E, E});
    rows.push_back(row_t'{5, 1, 1, RD, addr_of(tags[9], 0), 0, 0, 1, 0, 0, 1, D, E});

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      r = rows[i];
      @(negedge clk_i);
      xbar_bank_htu_valid_i = r.valid;
      htu_isu_allow_in_i = r.allow;
      xbar_bank_htu_opcode_i = r.op;
      xbar_bank_htu_addr_i = r.addr;
      xbar_bank_htu_ch_id_i = i[1:0];
      xbar_bank_htu_wbuffer_id_i = i[7:0];
      isu_htu_already_done_valid_i = r.done;
      isu_htu_set_way_i = r.done_sw;
      #1;
      cycles = 0;
      while (r.allow && xbar_bank_htu_ready_o !== 1'b1 && cycles < READY_TIMEOUT) begin
        @(negedge clk_i);
        #1;
        cycles++;
      end
      if (cycles == READY_TIMEOUT) begin
        timed_out = 1'b1;
        $display("ready stayed low for %0d cycles at row %0d", READY_TIMEOUT, i);
      end
      compare("xbar_bank_htu_ready_o", xbar_bank_htu_ready_o, r.rdy);
      compare("htu_isu_valid_o", htu_isu_valid_o, r.valid);
      compare("htu_isu_linefill_valid_o", htu_isu_linefill_valid_o, r.fill);
      compare("htu_isu_opcode_o", htu_isu_opcode_o, {r.evict, r.op == WR});
      compare("htu_isu_set_way_offset_o", htu_isu_set_way_offset_o, {3'd3, r.way, r.addr[4]});
      compare("htu_isu_linefill_set_o", htu_isu_linefill_set_o, 3'd3);
      compare("htu_isu_linefill_way_o", htu_isu_linefill_way_o, r.way);
      compare("htu_isu_offset0_state_o", htu_isu_offset0_state_o, r.off0);
      compare("htu_isu_offset1_state_o", htu_isu_offset1_state_o, r.off1);
      compare("htu_isu_ch_id_o", htu_isu_ch_id_o, i[1:0]);
      compare("htu_isu_wbuffer_id_o", htu_isu_wbuffer_id_o, i[7:0]);
      if (i == rows.size() - 1 || rows[i+1].test != r.test) begin
        n_tests++;
        $display("test %0d %s: %s, %0d errors", r.test, test_name[r.test-1],
                 (errors == first_err) ? "ok" : "failed", errors - first_err);
        first_err = errors;
      end
    end

    @(negedge clk_i);
    xbar_bank_htu_valid_i = 1'b0;
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
src/htu_op_pkg.sv
src/htu_addr_pkg.sv
src/htu_lookup_if.sv
src/bank_htu_lookup.sv
src/bank_htu_set_entry.sv
src/bank_htu.sv
test/bank_htu_assertions.sv
test/tb_bank_htu.sv

// File: run.sh
#!/bin/sh
# build and run the bank_htu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bank_htu -f compile.f \
  -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^TEST PASS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
